// File: Bender.yml
package:
  name: apb_uart

sources:
  - common/apb_pkg.sv
  - common/uart_pkg.sv
  - rtl/sfifo.sv
  - uart/uart_regs.sv
  - uart/uart_tx.sv
  - uart/uart_rx.sv
  - rtl/apb_uart_top.sv
  - target: simulation
    files:
      - bench/tb_apb_uart.sv

// File: bench/tb_apb_uart.sv
// Testbench for the APB UART with APB tasks, serial line model, checks, watchdog and report

`timescale 1ns/1ps

module tb_apb_uart;

    localparam int log2_depth = 4;
    localparam int fifo_max   = 2 ** log2_depth - 1;
    localparam int n_tx_bytes = 6;
    // Frames on the line in the transmit, frame error and overflow tests
    localparam int frames_total = n_tx_bytes + 1 + 16;
    localparam longint wd_limit_ns = longint'(frames_total) * 10 * 16 * 10 * 2 + 10000;

    logic              i_clk;
    logic              i_nrst;
    apb_pkg::apb_req_t req;
    apb_pkg::apb_rsp_t rsp;
    logic              txd;
    logic              rxd;
    logic              drv_rxd;
    logic              loop_en;

    int         err_cnt;
    int         tests_run;
    int         tests_failed;
    int         cur_baud;
    string      cur_test;
    logic [31:0] rng_state;
    logic [7:0]  tx_seen[$];
    logic [7:0]  sent[$];

    // Line decoder state
    logic       dec_busy;
    logic       dec_prev;
    int         dec_cnt;
    int         dec_idx;
    logic [7:0] dec_byte;

    apb_uart_top #(
        .log2_depth(log2_depth)
    ) dut_i (
        .i_clk (i_clk),
        .i_nrst(i_nrst),
        .i_apb (req),
        .i_rxd (rxd),
        .o_apb (rsp),
        .o_txd (txd)
    );

    // Loopback by default, or frames from send_frame
    assign rxd = loop_en ? txd : drv_rxd;

    always #5 i_clk = ~i_clk;

    task automatic flag_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    function automatic logic [7:0] rand_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    // Status for a TX FIFO count with the RX FIFO empty and its threshold zero
    function automatic logic [7:0] expect_status(input int cnt, input int thr);
        return {4'b0010, cnt > thr, cnt < thr, cnt == 0, cnt == fifo_max};
    endfunction

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, output logic err);
        @(negedge i_clk);
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = 1'b1;
        req.paddr   = addr;
        req.pwdata  = data;
        @(negedge i_clk);
        req.penable = 1'b1;
        @(posedge i_clk);
        err = rsp.pslverr;
        @(negedge i_clk);
        req = '0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data, output logic err);
        @(negedge i_clk);
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = 1'b0;
        req.paddr   = addr;
        req.pwdata  = '0;
        @(negedge i_clk);
        req.penable = 1'b1;
        @(posedge i_clk);
        data = rsp.prdata;
        err  = rsp.pslverr;
        @(negedge i_clk);
        req = '0;
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_nrst = 1'b0;
        repeat (2) @(negedge i_clk);
        i_nrst   = 1'b1;
        cur_baud = 16;
    endtask

    task automatic set_baud(input int baud);
        logic err;
        write_reg(apb_pkg::addr_baud, baud, err);
        cur_baud = baud;
        assert (!err) else flag_error("baud write returned pslverr");
    endtask

    // 8N1 frame on i_rxd with a stop bit level chosen by the caller
    task automatic send_frame(input logic [7:0] data, input logic stop);
        logic [9:0] bits;
        bits = {stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge i_clk);
            drv_rxd = bits[i];
            repeat (cur_baud - 1) @(negedge i_clk);
        end
        @(negedge i_clk);
        drv_rxd = 1'b1;
    endtask

    task automatic wait_rx_word(input int idx);
        logic [31:0] st;
        logic        err;
        logic        ready;
        ready = 1'b0;
        for (int polls = 0; polls < 200 && !ready; polls++) begin
            read_reg(apb_pkg::addr_status, st, err);
            ready = !st[5];
        end
        if (!ready) begin
            $display("Receive FIFO stayed empty while waiting for word %0d", idx);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        int n;
        n = err_cnt - errs_at_start;
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("test %-18s %s (%0d errors)", name, (n == 0) ? "ok" : "failed", n);
    endtask

    // Mid-bit sampler on o_txd that collects bytes in tx_seen
    always @(negedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            dec_busy = 1'b0;
            dec_prev = 1'b1;
            dec_cnt  = 0;
            dec_idx  = 0;
        end else begin
            if (!dec_busy) begin
                if (dec_prev && !txd) begin
                    dec_busy = 1'b1;
                    dec_cnt  = cur_baud / 2 - 1;
                    dec_idx  = 0;
                end
            end else if (dec_cnt != 0) begin
                dec_cnt--;
            end else begin
                dec_cnt = cur_baud - 1;
                if (dec_idx == 0) begin
                    assert (!txd) else flag_error("start bit high at mid-bit on o_txd");
                end else if (dec_idx <= 8) begin
                    dec_byte[dec_idx-1] = txd;
                end else begin
                    assert (txd) else flag_error("stop bit low at mid-bit on o_txd");
                    tx_seen.push_back(dec_byte);
                    dec_busy = 1'b0;
                end
                dec_idx++;
            end
            dec_prev = txd;
        end
    end

    // No wait states, and pslverr only inside the access cycle
    assert property (@(posedge i_clk) disable iff (!i_nrst)
        rsp.pready == (req.psel && req.penable))
        else flag_error("pready does not match the access cycle");

    assert property (@(posedge i_clk) disable iff (!i_nrst)
        !rsp.pready |-> !rsp.pslverr)
        else flag_error("pslverr outside an access cycle");

    initial begin
        #(wd_limit_ns);
        $display("Watchdog expired, test %s did not finish", cur_test);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [8:0]  exp_word;
        int          e0;

        i_clk        = 1'b0;
        i_nrst       = 1'b0;
        req          = '0;
        drv_rxd      = 1'b1;
        loop_en      = 1'b1;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_baud     = 16;
        rng_state    = 32'h6061_5014;
        cur_test     = "reset";
        repeat (2) @(negedge i_clk);
        i_nrst = 1'b1;

        e0 = err_cnt;
        assert (!rsp.pready && !rsp.pslverr) else flag_error("APB response active after reset");
        assert (txd) else flag_error("o_txd low after reset");
        read_reg(apb_pkg::addr_status, rd, err);
        assert (rd == 32'h22 && !err) else flag_error($sformatf("status 0x%0h after reset", rd));
        read_reg(apb_pkg::addr_baud, rd, err);
        assert (rd == 32'd16) else flag_error($sformatf("baud %0d after reset", rd));
        read_reg(apb_pkg::addr_ctrl, rd, err);
        assert (rd == 32'd0) else flag_error($sformatf("ctrl 0x%0h after reset", rd));
        finish_test("reset state", e0);

        cur_test = "transmit framing";
        e0 = err_cnt;
        set_baud(8);
        for (int i = 0; i < n_tx_bytes; i++) begin
            sent.push_back(rand_byte());
            write_reg(apb_pkg::addr_data, sent[i], err);
            assert (!err) else flag_error("data write returned pslverr");
        end
        while (tx_seen.size() < n_tx_bytes) @(posedge i_clk);
        for (int i = 0; i < n_tx_bytes; i++) begin
            assert (tx_seen[i] == sent[i])
                else flag_error($sformatf("frame %0d carried 0x%0h, expected 0x%0h",
                                          i, tx_seen[i], sent[i]));
        end
        finish_test("transmit framing", e0);

        cur_test = "loopback receive";
        e0 = err_cnt;
        for (int i = 0; i < n_tx_bytes; i++) begin
            wait_rx_word(i);
            read_reg(apb_pkg::addr_data, rd, err);
            assert (rd == {24'd0, sent[i]} && !err)
                else flag_error($sformatf("rx word %0d read 0x%0h", i, rd));
        end
        read_reg(apb_pkg::addr_data, rd, err);
        assert (rd == 32'd0 && !err) else flag_error("read of empty RX FIFO not zero");
        finish_test("loopback receive", e0);

        cur_test = "thresholds and full";
        e0 = err_cnt;
        set_baud(16'hFFFF);
        write_reg(apb_pkg::addr_ctrl, 32'h0000_0006, err);
        // The first byte leaves for the serializer at once
        for (int i = 1; i <= fifo_max + 1; i++) begin
            write_reg(apb_pkg::addr_data, rand_byte(), err);
            assert (!err) else flag_error($sformatf("write %0d returned pslverr", i));
            read_reg(apb_pkg::addr_status, rd, err);
            assert (rd[7:0] == expect_status(i - 1, 6))
                else flag_error($sformatf("status 0x%0h after %0d writes", rd, i));
        end
        write_reg(apb_pkg::addr_data, rand_byte(), err);
        assert (err) else flag_error("write to full TX FIFO without pslverr");
        read_reg(apb_pkg::addr_status, rd, err);
        assert (rd[7:0] == expect_status(fifo_max, 6))
            else flag_error($sformatf("status 0x%0h after dropped write", rd));
        apply_reset();
        finish_test("thresholds and full", e0);

        cur_test = "frame error and overflow";
        e0 = err_cnt;
        loop_en = 1'b0;
        sent.delete();
        exp_word = {1'b1, rand_byte()};
        send_frame(exp_word[7:0], 1'b0);
        wait_rx_word(0);
        read_reg(apb_pkg::addr_data, rd, err);
        assert (rd == {23'd0, exp_word}) else flag_error($sformatf("ferr word read 0x%0h", rd));
        for (int i = 0; i <= fifo_max; i++) begin
            sent.push_back(rand_byte());
            send_frame(sent[i], 1'b1);
        end
        read_reg(apb_pkg::addr_status, rd, err);
        assert (rd[4]) else flag_error($sformatf("rx_full clear, status 0x%0h", rd));
        for (int i = 0; i < fifo_max; i++) begin
            read_reg(apb_pkg::addr_data, rd, err);
            assert (rd == {24'd0, sent[i]})
                else flag_error($sformatf("overflow word %0d read 0x%0h", i, rd));
        end
        read_reg(apb_pkg::addr_data, rd, err);
        assert (rd == 32'd0 && !err) else flag_error("word past the full FIFO was kept");
        loop_en = 1'b1;
        finish_test("frame error and overflow", e0);

        cur_test = "address errors";
        e0 = err_cnt;
        write_reg(apb_pkg::addr_ctrl, 32'h0000_0305, err);
        set_baud(20);
        write_reg(4'h6, 32'hFFFF_FFFF, err);
        assert (err) else flag_error("unmapped write without pslverr");
        read_reg(4'h1, rd, err);
        assert (err) else flag_error("unmapped read without pslverr");
        read_reg(apb_pkg::addr_ctrl, rd, err);
        assert (rd == 32'h0000_0305) else flag_error($sformatf("ctrl changed to 0x%0h", rd));
        read_reg(apb_pkg::addr_baud, rd, err);
        assert (rd == 32'd20) else flag_error($sformatf("baud changed to %0d", rd));
        finish_test("address errors", e0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: common/apb_pkg.sv
// APB request and response structs, register map offsets

package apb_pkg;

    // Driven by the bus master
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Returned by the slave
    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    // Register map
    // Write pushes a TX byte, read pops an RX word
    localparam logic [3:0] addr_data   = 4'h0;
    // Read-only FIFO flags
    localparam logic [3:0] addr_status = 4'h4;
    // tx_thresh in 3:0, rx_thresh in 11:8
    localparam logic [3:0] addr_ctrl   = 4'h8;
    // Clocks per serial bit
    localparam logic [3:0] addr_baud   = 4'hC;

    // Field positions inside the ctrl register
    localparam int ctrl_tx_lsb = 0;
    localparam int ctrl_rx_lsb = 8;

    // Bit 8 of a data read carries the framing error
    localparam int data_ferr_bit = 8;

endpackage

// File: common/uart_pkg.sv
// Serial-side types: baud divider, receive word, status flag layout

package uart_pkg;

    // Divider width in bits
    localparam int baud_w = 16;

    typedef logic [baud_w-1:0] baud_t;

    // Clocks per bit after reset
    localparam baud_t baud_default = baud_t'(16);

    // Payload of the receive FIFO
    typedef struct packed {
        logic [7:0] data;
        logic       ferr;   // stop bit sampled low
    } rx_word_t;

    // Status register, bit 7 down to bit 0
    typedef struct packed {
        logic rx_greater;
        logic rx_less;
        logic rx_empty;
        logic rx_full;
        logic tx_greater;
        logic tx_less;
        logic tx_empty;
        logic tx_full;
    } status_t;

    // Frame layout for 8N1
    localparam int data_bits = 8;

    // Width of the bit index inside a frame
    localparam int bit_idx_w = 3;

endpackage

// File: rtl/apb_uart_top.sv
// APB UART top: register block, TX and RX FIFOs, serializer, deserializer

`timescale 1ns/1ps

module apb_uart_top #(
    parameter int log2_depth = 4
) (
    input  logic              i_clk,
    input  logic              i_nrst,
    input  apb_pkg::apb_req_t i_apb,
    input  logic              i_rxd,
    output apb_pkg::apb_rsp_t o_apb,
    output logic              o_txd
);

    uart_pkg::status_t     status;
    uart_pkg::baud_t       baud;
    logic [log2_depth-1:0] tx_thresh;
    logic [log2_depth-1:0] rx_thresh;

    logic                  tx_we;
    logic [7:0]            tx_wdata;
    logic                  tx_re;
    logic [7:0]            tx_rdata;

    logic                  rx_we;
    uart_pkg::rx_word_t    rx_wdata;
    logic                  rx_re;
    uart_pkg::rx_word_t    rx_rdata;

    uart_regs #(
        .log2_depth(log2_depth)
    ) regs_i (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_apb      (i_apb),
        .i_status   (status),
        .i_rx_word  (rx_rdata),
        .o_apb      (o_apb),
        .o_tx_we    (tx_we),
        .o_tx_wdata (tx_wdata),
        .o_rx_re    (rx_re),
        .o_tx_thresh(tx_thresh),
        .o_rx_thresh(rx_thresh),
        .o_baud     (baud)
    );

    sfifo #(
        .log2_depth(log2_depth),
        .payload_t (logic [7:0])
    ) tx_fifo_i (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_thresh (tx_thresh),
        .i_we     (tx_we),
        .i_wdata  (tx_wdata),
        .i_re     (tx_re),
        .o_rdata  (tx_rdata),
        .o_full   (status.tx_full),
        .o_empty  (status.tx_empty),
        .o_less   (status.tx_less),
        .o_greater(status.tx_greater)
    );

    // Words arriving on a full RX FIFO are dropped there
    sfifo #(
        .log2_depth(log2_depth),
        .payload_t (uart_pkg::rx_word_t)
    ) rx_fifo_i (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_thresh (rx_thresh),
        .i_we     (rx_we),
        .i_wdata  (rx_wdata),
        .i_re     (rx_re),
        .o_rdata  (rx_rdata),
        .o_full   (status.rx_full),
        .o_empty  (status.rx_empty),
        .o_less   (status.rx_less),
        .o_greater(status.rx_greater)
    );

    uart_tx tx_i (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_baud (baud),
        .i_empty(status.tx_empty),
        .i_data (tx_rdata),
        .o_re   (tx_re),
        .o_txd  (o_txd)
    );

    uart_rx rx_i (
        .i_clk (i_clk),
        .i_nrst(i_nrst),
        .i_baud(baud),
        .i_rxd (i_rxd),
        .o_we  (rx_we),
        .o_word(rx_wdata)
    );

endmodule

// File: rtl/sfifo.sv
// Synchronous FIFO with first-word fall-through and threshold flags

`timescale 1ns/1ps

module sfifo #(
    parameter int  log2_depth = 4,
    parameter type payload_t  = logic [7:0]
) (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic [log2_depth-1:0] i_thresh,
    input  logic                  i_we,
    input  payload_t              i_wdata,
    input  logic                  i_re,
    output payload_t              o_rdata,
    output logic                  o_full,
    output logic                  o_empty,
    output logic                  o_less,
    output logic                  o_greater
);

    localparam int depth = 2 ** log2_depth;

    payload_t              mem [depth];
    logic [log2_depth-1:0] wr_cnt;
    logic [log2_depth-1:0] rd_cnt;
    logic [log2_depth-1:0] total_cnt;

    logic do_write;
    logic do_read;

    // Flags come from the registered count only
    assign o_empty   = (total_cnt == '0);
    // One slot stays unused, so full is one below depth
    assign o_full    = (total_cnt == log2_depth'(depth - 1));
    assign o_less    = (total_cnt < i_thresh);
    assign o_greater = (total_cnt > i_thresh);

    // Head entry is visible without a read
    assign o_rdata = mem[rd_cnt];

    assign do_read  = i_re && !o_empty;
    // A full FIFO still takes a write when a read frees a slot
    assign do_write = i_we && (!o_full || do_read);

    always_ff @(posedge i_clk) begin
        if (do_write) begin
            mem[wr_cnt] <= i_wdata;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_cnt    <= '0;
            rd_cnt    <= '0;
            total_cnt <= '0;
        end else begin
            if (do_write) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (do_read) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            // Push and pop together leave the count as is
            case ({do_write, do_read})
                2'b10: begin
                    total_cnt <= total_cnt + 1'b1;
                end
                2'b01: begin
                    total_cnt <= total_cnt - 1'b1;
                end
                default: begin
                    total_cnt <= total_cnt;
                end
            endcase
        end
    end

endmodule

// File: sim.f
common/apb_pkg.sv
common/uart_pkg.sv
rtl/sfifo.sv
uart/uart_regs.sv
uart/uart_tx.sv
uart/uart_rx.sv
rtl/apb_uart_top.sv
bench/tb_apb_uart.sv

// File: uart/uart_regs.sv
// APB register block: data, status, ctrl and baud registers, FIFO strobes

`timescale 1ns/1ps

module uart_regs #(
    parameter int log2_depth = 4
) (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  apb_pkg::apb_req_t     i_apb,
    input  uart_pkg::status_t     i_status,
    input  uart_pkg::rx_word_t    i_rx_word,
    output apb_pkg::apb_rsp_t     o_apb,
    output logic                  o_tx_we,
    output logic [7:0]            o_tx_wdata,
    output logic                  o_rx_re,
    output logic [log2_depth-1:0] o_tx_thresh,
    output logic [log2_depth-1:0] o_rx_thresh,
    output uart_pkg::baud_t       o_baud
);

    logic                  access;
    logic                  hit_data;
    logic                  hit_status;
    logic                  hit_ctrl;
    logic                  hit_baud;
    logic                  mapped;
    logic [log2_depth-1:0] tx_thresh_q;
    logic [log2_depth-1:0] rx_thresh_q;
    uart_pkg::baud_t       baud_q;
    logic [31:0]           rdata;

    // Second phase of a transfer, never stalled
    assign access = i_apb.psel && i_apb.penable;

    assign hit_data   = (i_apb.paddr == apb_pkg::addr_data);
    assign hit_status = (i_apb.paddr == apb_pkg::addr_status);
    assign hit_ctrl   = (i_apb.paddr == apb_pkg::addr_ctrl);
    assign hit_baud   = (i_apb.paddr == apb_pkg::addr_baud);
    assign mapped     = hit_data || hit_status || hit_ctrl || hit_baud;

    // Push only with room, pop only with data
    assign o_tx_we    = access && i_apb.pwrite && hit_data && !i_status.tx_full;
    assign o_tx_wdata = i_apb.pwdata[7:0];
    assign o_rx_re    = access && !i_apb.pwrite && hit_data && !i_status.rx_empty;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            tx_thresh_q <= '0;
            rx_thresh_q <= '0;
            baud_q      <= uart_pkg::baud_default;
        end else if (access && i_apb.pwrite) begin
            if (hit_ctrl) begin
                tx_thresh_q <= i_apb.pwdata[apb_pkg::ctrl_tx_lsb +: log2_depth];
                rx_thresh_q <= i_apb.pwdata[apb_pkg::ctrl_rx_lsb +: log2_depth];
            end
            if (hit_baud) begin
                baud_q <= i_apb.pwdata[uart_pkg::baud_w-1:0];
            end
        end
    end

    // Read mux
    always_comb begin
        rdata = '0;
        if (hit_data) begin
            // Empty FIFO reads as zero
            if (!i_status.rx_empty) begin
                rdata[7:0]                    = i_rx_word.data;
                rdata[apb_pkg::data_ferr_bit] = i_rx_word.ferr;
            end
        end else if (hit_status) begin
            rdata[7:0] = i_status;
        end else if (hit_ctrl) begin
            rdata[apb_pkg::ctrl_tx_lsb +: log2_depth] = tx_thresh_q;
            rdata[apb_pkg::ctrl_rx_lsb +: log2_depth] = rx_thresh_q;
        end else if (hit_baud) begin
            rdata[uart_pkg::baud_w-1:0] = baud_q;
        end
    end

    always_comb begin
        o_apb.pready  = access;
        // Unmapped offset, or a byte dropped on a full TX FIFO
        o_apb.pslverr = access && (!mapped ||
                        (i_apb.pwrite && hit_data && i_status.tx_full));
        o_apb.prdata  = rdata;
    end

    assign o_tx_thresh = tx_thresh_q;
    assign o_rx_thresh = rx_thresh_q;
    assign o_baud      = baud_q;

endmodule

// File: uart/uart_rx.sv
// Receive deserializer with line synchronizer and mid-bit sampling

`timescale 1ns/1ps

module uart_rx (
    input  logic               i_clk,
    input  logic               i_nrst,
    input  uart_pkg::baud_t    i_baud,
    input  logic               i_rxd,
    output logic               o_we,
    output uart_pkg::rx_word_t o_word
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t                      state;
    logic                           rxd_s1;
    logic                           rxd_s2;
    logic                           rxd_d;
    logic                           fall;
    uart_pkg::baud_t                cnt;
    uart_pkg::baud_t                half_load;
    logic [uart_pkg::bit_idx_w-1:0] bit_idx;
    logic [7:0]                     shift;
    logic                           sample;

    // Two-flop synchronizer plus one stage for edge detect
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rxd_s1 <= 1'b1;
            rxd_s2 <= 1'b1;
            rxd_d  <= 1'b1;
        end else begin
            rxd_s1 <= i_rxd;
            rxd_s2 <= rxd_s1;
            rxd_d  <= rxd_s2;
        end
    end

    assign fall   = rxd_d && !rxd_s2;
    assign sample = (cnt == '0);

    // Counter value that lands on the middle of the start bit
    assign half_load = ((i_baud >> 1) == '0) ? '0 : (i_baud >> 1) - 1'b1;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state   <= st_idle;
            cnt     <= '0;
            bit_idx <= '0;
            shift   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (fall) begin
                        cnt   <= half_load;
                        state <= st_start;
                    end
                end
                default: begin
                    if (!sample) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        cnt <= i_baud - 1'b1;
                        if (state == st_start) begin
                            // High at mid start bit means a glitch
                            bit_idx <= '0;
                            state   <= rxd_s2 ? st_idle : st_data;
                        end else if (state == st_data) begin
                            shift   <= {rxd_s2, shift[7:1]};
                            bit_idx <= bit_idx + 1'b1;
                            if (bit_idx == uart_pkg::bit_idx_w'(uart_pkg::data_bits - 1)) begin
                                state <= st_stop;
                            end
                        end else begin
                            state <= st_idle;
                        end
                    end
                end
            endcase
        end
    end

    // Word leaves on the stop-bit sample
    assign o_we        = (state == st_stop) && sample;
    assign o_word.data = shift;
    assign o_word.ferr = !rxd_s2;

endmodule

// File: uart/uart_tx.sv
// Transmit serializer for 8N1 frames fed from the TX FIFO

`timescale 1ns/1ps

module uart_tx (
    input  logic            i_clk,
    input  logic            i_nrst,
    input  uart_pkg::baud_t i_baud,
    input  logic            i_empty,
    input  logic [7:0]      i_data,
    output logic            o_re,
    output logic            o_txd
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } tx_state_t;

    tx_state_t                        state;
    uart_pkg::baud_t                  cnt;
    logic [uart_pkg::bit_idx_w-1:0]   bit_idx;
    logic [7:0]                       shift;
    logic                             bit_end;

    // Last cycle of the current bit
    assign bit_end = (cnt == '0);

    // Pop when idle, or straight after the stop bit for back-to-back frames
    assign o_re = !i_empty && ((state == st_idle) || (state == st_stop && bit_end));

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state   <= st_idle;
            cnt     <= '0;
            bit_idx <= '0;
            shift   <= '0;
        end else begin
            if (o_re) begin
                shift   <= i_data;
                cnt     <= i_baud - 1'b1;
                bit_idx <= '0;
                state   <= st_start;
            end else if (state != st_idle) begin
                if (!bit_end) begin
                    cnt <= cnt - 1'b1;
                end else begin
                    cnt <= i_baud - 1'b1;
                    case (state)
                        st_start: state <= st_data;
                        st_data: begin
                            shift   <= shift >> 1;
                            bit_idx <= bit_idx + 1'b1;
                            if (bit_idx == uart_pkg::bit_idx_w'(uart_pkg::data_bits - 1)) begin
                                state <= st_stop;
                            end
                        end
                        default: state <= st_idle;
                    endcase
                end
            end
        end
    end

    // Line level follows the state, LSB first
    always_comb begin
        case (state)
            st_start: o_txd = 1'b0;
            st_data:  o_txd = shift[0];
            default:  o_txd = 1'b1;
        endcase
    end

endmodule
